// ==== lstm_macros.svh ====
/*
 * LSTM fixed-point parameters
 * word width, fraction bits, lane count and the constants
 * used by saturation and the piecewise linear activations
 */
`ifndef LSTM_MACROS_SVH
`define LSTM_MACROS_SVH

// signed word, 24 bits with 20 fraction bits
`define LSTM_WIDTH 24
`define LSTM_FRAC 20

// one lane per gate, order a i f o
`define LSTM_LANES 4

// fixed-point constants as plain integers, cast at the point of use
`define LSTM_ONE (1 << `LSTM_FRAC)
`define LSTM_HALF (1 << (`LSTM_FRAC - 1))

// saturation limits of a WIDTH-bit signed word
`define LSTM_MAX ((1 << (`LSTM_WIDTH - 1)) - 1)
`define LSTM_MIN (-(1 << (`LSTM_WIDTH - 1)))

`endif

// ==== lstm_pkg.sv ====
/*
 * LSTM cell types and fixed-point helpers
 * the words, gate lane names and structs passed between the three
 * pipeline stages, with the multiply, saturate and activation functions
 */
`include "lstm_macros.svh"

package lstm_pkg;

	// one fixed-point word
	typedef logic signed [`LSTM_WIDTH-1:0] fix_t;
	// full product width, also holds three-term sums without overflow
	typedef logic signed [2*`LSTM_WIDTH-1:0] prod_t;

	// lane index of every per-gate array
	typedef enum logic [1:0] {
		GATE_A,
		GATE_I,
		GATE_F,
		GATE_O
	} gate_id_t;

	// operands of one term, lane order a i f o
	typedef struct packed {
		fix_t [`LSTM_LANES-1:0] x;
		fix_t [`LSTM_LANES-1:0] w;
		fix_t [`LSTM_LANES-1:0] h;
		fix_t [`LSTM_LANES-1:0] u;
	} lstm_operands_t;

	typedef struct packed {
		fix_t b_a;
		fix_t b_i;
		fix_t b_f;
		fix_t b_o;
	} lstm_bias_t;

	// stage 1 result
	typedef struct packed {
		logic                   valid;
		fix_t [`LSTM_LANES-1:0] x_sum;
		fix_t [`LSTM_LANES-1:0] h_sum;
		lstm_bias_t             bias;
		fix_t                   prev_state;
	} lstm_sums_t;

	// stage 2 result, activated gates
	typedef struct packed {
		logic valid;
		fix_t a;
		fix_t i;
		fix_t f;
		fix_t o;
		fix_t prev_state;
	} lstm_gates_t;

	typedef struct packed {
		fix_t c;
		fix_t h;
	} lstm_cell_t;

	// full product, arithmetic shift truncates toward minus infinity
	function automatic prod_t fix_mul(input fix_t a, input fix_t b);
		prod_t p;
		p = a * b;
		return p >>> `LSTM_FRAC;
	endfunction

	// clamp a wide value into the signed word range
	function automatic fix_t fix_sat(input prod_t v);
		if (v > `LSTM_MAX)
			return fix_t'(`LSTM_MAX);
		if (v < `LSTM_MIN)
			return fix_t'(`LSTM_MIN);
		return fix_t'(v);
	endfunction

	// hard tanh, clamp to -1..+1
	function automatic fix_t hard_tanh(input fix_t x);
		if (x > `LSTM_ONE)
			return fix_t'(`LSTM_ONE);
		if (x < -`LSTM_ONE)
			return fix_t'(-`LSTM_ONE);
		return x;
	endfunction

	// hard sigmoid, x/4 + 1/2 clamped to 0..1
	function automatic fix_t hard_sigmoid(input fix_t x);
		prod_t v;
		v = prod_t'(x);
		// divide by 4 rounds toward minus infinity as well
		v = (v >>> 2) + `LSTM_HALF;
		if (v > `LSTM_ONE)
			return fix_t'(`LSTM_ONE);
		if (v < 0)
			return '0;
		return fix_t'(v);
	endfunction

endpackage

// ==== lstm_mac_array.sv ====
/*
 * LSTM stage 1, MAC array
 * four x*w and four h*u saturating accumulators, one pair per gate,
 * with capture of bias and previous cell state on the last term
 */
`include "lstm_macros.svh"

module lstm_mac_array
	import lstm_pkg::*;
(
	input  logic           clk,
	input  logic           i_arst_n,
	input  logic           i_mac_en,
	input  logic           i_acc_x,
	input  logic           i_acc_h,
	input  logic           i_eval,
	input  lstm_operands_t i_ops,
	input  lstm_bias_t     i_bias,
	input  fix_t           i_prev_state,
	output lstm_sums_t     o_sums
);

	// accumulators double as the stage 1 output register
	fix_t       acc_x [`LSTM_LANES];
	fix_t       acc_h [`LSTM_LANES];
	logic       sums_valid;
	lstm_bias_t bias_q;
	fix_t       prev_q;

	//////////////////////////////////////////////////////////////////////
	// accumulators
	//////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < `LSTM_LANES; g++) begin : g_lane
		prod_t prod_x;
		prod_t prod_h;

		assign prod_x = fix_mul(i_ops.x[g], i_ops.w[g]);
		assign prod_h = fix_mul(i_ops.h[g], i_ops.u[g]);

		// load when acc is low, add when high, hold without mac_en
		always_ff @(posedge clk or negedge i_arst_n) begin
			if (!i_arst_n) begin
				acc_x[g] <= '0;
				acc_h[g] <= '0;
			end else if (i_mac_en) begin
				// the product is kept wide so a load saturates too
				acc_x[g] <= i_acc_x ? fix_sat(prod_t'(acc_x[g]) + prod_x) : fix_sat(prod_x);
				acc_h[g] <= i_acc_h ? fix_sat(prod_t'(acc_h[g]) + prod_h) : fix_sat(prod_h);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// valid and side operands
	//////////////////////////////////////////////////////////////////////

	// valid lines up with the sums updated by the last term
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			sums_valid <= 1'b0;
		else
			sums_valid <= i_eval;
	end

	always_ff @(posedge clk) begin
		if (i_eval) begin
			bias_q <= i_bias;
			prev_q <= i_prev_state;
		end
	end

	always_comb begin
		o_sums.valid = sums_valid;
		for (int l = 0; l < `LSTM_LANES; l++) begin
			o_sums.x_sum[l] = acc_x[l];
			o_sums.h_sum[l] = acc_h[l];
		end
		o_sums.bias       = bias_q;
		o_sums.prev_state = prev_q;
	end

	// the last term must itself be an operand cycle
	a_eval_with_mac: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_eval |-> i_mac_en);

endmodule

// ==== lstm_gate_activation.sv ====
/*
 * LSTM stage 2, gate activation
 * sums x-term, h-term and bias per gate with saturation, then
 * hard tanh on the candidate and hard sigmoid on i, f and o
 */
`include "lstm_macros.svh"

module lstm_gate_activation
	import lstm_pkg::*;
(
	input  logic        clk,
	input  logic        i_arst_n,
	input  lstm_sums_t  i_sums,
	output lstm_gates_t o_gates
);

	fix_t bias_lane [`LSTM_LANES];
	fix_t gate_sum [`LSTM_LANES];
	fix_t act [`LSTM_LANES];

	logic gates_valid;
	fix_t a_q;
	fix_t i_q;
	fix_t f_q;
	fix_t o_q;
	fix_t prev_q;

	//////////////////////////////////////////////////////////////////////
	// three-input sums and activations
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// bias struct into lane order
		bias_lane[GATE_A] = i_sums.bias.b_a;
		bias_lane[GATE_I] = i_sums.bias.b_i;
		bias_lane[GATE_F] = i_sums.bias.b_f;
		bias_lane[GATE_O] = i_sums.bias.b_o;

		// one saturation over the whole three-term sum
		for (int l = 0; l < `LSTM_LANES; l++) begin
			gate_sum[l] = fix_sat(prod_t'(i_sums.x_sum[l]) + prod_t'(i_sums.h_sum[l])
				+ prod_t'(bias_lane[l]));
		end

		// candidate
		act[GATE_A] = hard_tanh(gate_sum[GATE_A]);
		// input, forget and output gates
		act[GATE_I] = hard_sigmoid(gate_sum[GATE_I]);
		act[GATE_F] = hard_sigmoid(gate_sum[GATE_F]);
		act[GATE_O] = hard_sigmoid(gate_sum[GATE_O]);
	end

	//////////////////////////////////////////////////////////////////////
	// stage register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			gates_valid <= 1'b0;
		else
			gates_valid <= i_sums.valid;
	end

	// payload only moves with a result
	always_ff @(posedge clk) begin
		if (i_sums.valid) begin
			a_q    <= act[GATE_A];
			i_q    <= act[GATE_I];
			f_q    <= act[GATE_F];
			o_q    <= act[GATE_O];
			prev_q <= i_sums.prev_state;
		end
	end

	assign o_gates.valid      = gates_valid;
	assign o_gates.a          = a_q;
	assign o_gates.i          = i_q;
	assign o_gates.f          = f_q;
	assign o_gates.o          = o_q;
	assign o_gates.prev_state = prev_q;

	// gate outputs stay inside 0..ONE, so stage 3 products cannot overflow
	a_sigm_range: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_gates.valid |-> (o_gates.i >= 0 && o_gates.i <= `LSTM_ONE)
		&& (o_gates.f >= 0 && o_gates.f <= `LSTM_ONE)
		&& (o_gates.o >= 0 && o_gates.o <= `LSTM_ONE));

	// candidate inside -ONE..ONE
	a_tanh_range: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_gates.valid |-> (o_gates.a >= -`LSTM_ONE && o_gates.a <= `LSTM_ONE));

endmodule

// ==== lstm_state_update.sv ====
/*
 * LSTM stage 3, state update
 * new cell state c = a*i + f*c_prev and hidden output
 * h = tanh(c)*o, registered with the result valid
 */
module lstm_state_update
	import lstm_pkg::*;
(
	input  logic        clk,
	input  logic        i_arst_n,
	input  lstm_gates_t i_gates,
	output logic        o_valid,
	output lstm_cell_t  o_cell
);

	prod_t      ai_prod;
	prod_t      fc_prod;
	prod_t      h_prod;
	fix_t       c_tanh;
	lstm_cell_t cell_next;
	lstm_cell_t cell_q;

	//////////////////////////////////////////////////////////////////////
	// cell state and hidden output
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// candidate scaled by input gate
		ai_prod = fix_mul(i_gates.a, i_gates.i);
		// old state scaled by forget gate
		fc_prod = fix_mul(i_gates.f, i_gates.prev_state);
		cell_next.c = fix_sat(ai_prod + fc_prod);

		c_tanh = hard_tanh(cell_next.c);
		// both factors within one, product always fits
		h_prod = fix_mul(c_tanh, i_gates.o);
		cell_next.h = fix_sat(h_prod);
	end

	//////////////////////////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			o_valid <= 1'b0;
		else
			o_valid <= i_gates.valid;
	end

	// holds the last result between valid cycles
	always_ff @(posedge clk) begin
		if (i_gates.valid)
			cell_q <= cell_next;
	end

	assign o_cell = cell_q;

	// consumer samples on o_valid, so it must always be known
	a_valid_known: assert property (@(posedge clk) disable iff (!i_arst_n)
		!$isunknown(o_valid));

endmodule

// ==== lstm_core.sv ====
/*
 * LSTM core
 * three-stage cell pipeline, MAC array, gate activation and
 * state update, result three cycles after the last term
 */
module lstm_core
	import lstm_pkg::*;
(
	input  logic           clk,
	input  logic           i_arst_n,
	// operand strobes
	input  logic           i_mac_en,
	input  logic           i_acc_x,
	input  logic           i_acc_h,
	input  logic           i_eval,
	// operands and side inputs
	input  lstm_operands_t i_ops,
	input  lstm_bias_t     i_bias,
	input  fix_t           i_prev_state,
	// result
	output logic           o_valid,
	output lstm_cell_t     o_cell,
	// debug taps of stages 1 and 2
	output lstm_sums_t     o_sums,
	output lstm_gates_t    o_gates
);

	lstm_sums_t  sums;
	lstm_gates_t gates;

	// stage 1
	lstm_mac_array u_mac_array (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_mac_en     (i_mac_en),
		.i_acc_x      (i_acc_x),
		.i_acc_h      (i_acc_h),
		.i_eval       (i_eval),
		.i_ops        (i_ops),
		.i_bias       (i_bias),
		.i_prev_state (i_prev_state),
		.o_sums       (sums)
	);

	// stage 2
	lstm_gate_activation u_gate_activation (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_sums   (sums),
		.o_gates  (gates)
	);

	// stage 3
	lstm_state_update u_state_update (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_gates  (gates),
		.o_valid  (o_valid),
		.o_cell   (o_cell)
	);

	assign o_sums  = sums;
	assign o_gates = gates;

endmodule

// ==== tb_lstm_core.sv ====
/*
 * LSTM core testbench
 * random and corner-case operands against a fixed-point model of
 * the cell, with concurrent checks on sums, gates, latency and results
 */
`include "lstm_macros.svh"

module tb_lstm_core
	import lstm_pkg::*;
();

	logic           clk;
	logic           arst_n;
	logic           mac_en;
	logic           acc_x;
	logic           acc_h;
	logic           eval_in;
	lstm_operands_t ops;
	lstm_bias_t     bias;
	fix_t           prev_state;
	logic           valid;
	lstm_cell_t     cell_res;
	lstm_sums_t     sums;
	lstm_gates_t    gates;

	// model state, updated on the rising edge
	fix_t [`LSTM_LANES-1:0] ref_x;
	fix_t [`LSTM_LANES-1:0] ref_h;
	lstm_bias_t             ref_bias;
	fix_t                   ref_prev;
	logic [2:0]             eval_pipe;
	lstm_gates_t            exp_gates [64];
	lstm_cell_t             exp_cell [64];
	logic [5:0]             wr_idx;
	logic [5:0]             gate_idx;
	logic [5:0]             cell_idx;

	logic [31:0] rng_state;
	int          n_fail;
	int          n_tests;
	bit          timed_out;

	initial clk = 1'b0;
	always #4 clk = ~clk;

	lstm_core dut (
		.clk          (clk),
		.i_arst_n     (arst_n),
		.i_mac_en     (mac_en),
		.i_acc_x      (acc_x),
		.i_acc_h      (acc_h),
		.i_eval       (eval_in),
		.i_ops        (ops),
		.i_bias       (bias),
		.i_prev_state (prev_state),
		.o_valid      (valid),
		.o_cell       (cell_res),
		.o_sums       (sums),
		.o_gates      (gates)
	);

	//////////////////////////////////////////////////////////////////////
	// fixed-point reference
	//////////////////////////////////////////////////////////////////////

	function automatic fix_t saturate(input longint v);
		if (v > longint'(`LSTM_MAX))
			return fix_t'(`LSTM_MAX);
		if (v < longint'(`LSTM_MIN))
			return fix_t'(`LSTM_MIN);
		return fix_t'(v);
	endfunction

	// full product, then floor by the fraction bits
	function automatic longint scaled_product(input fix_t a, input fix_t b);
		longint p;
		p = longint'(a) * longint'(b);
		return p >>> `LSTM_FRAC;
	endfunction

	function automatic fix_t tanh_clip(input fix_t x);
		longint v;
		v = x;
		if (v > `LSTM_ONE)
			return fix_t'(`LSTM_ONE);
		if (v < -`LSTM_ONE)
			return fix_t'(-`LSTM_ONE);
		return x;
	endfunction

	// x/4 + 1/2 into 0..1
	function automatic fix_t sigmoid_clip(input fix_t x);
		longint v;
		v = (longint'(x) >>> 2) + `LSTM_HALF;
		if (v > `LSTM_ONE)
			return fix_t'(`LSTM_ONE);
		if (v < 0)
			return '0;
		return fix_t'(v);
	endfunction

	function automatic fix_t accumulate(input fix_t acc, input fix_t a, input fix_t b,
		input logic add);
		longint s;
		s = scaled_product(a, b);
		if (add)
			s = s + longint'(acc);
		return saturate(s);
	endfunction

	function automatic fix_t gate_sum(input fix_t x, input fix_t h, input fix_t b);
		return saturate(longint'(x) + longint'(h) + longint'(b));
	endfunction

	always @(posedge clk or negedge arst_n) begin : ref_model
		fix_t [`LSTM_LANES-1:0] nx;
		fix_t [`LSTM_LANES-1:0] nh;
		lstm_gates_t            g;
		lstm_cell_t             r;
		if (!arst_n) begin
			// everything in flight is dropped
			ref_x     <= '0;
			ref_h     <= '0;
			eval_pipe <= '0;
			wr_idx    <= '0;
			gate_idx  <= '0;
			cell_idx  <= '0;
		end else begin
			for (int l = 0; l < `LSTM_LANES; l++) begin
				nx[l] = mac_en ? accumulate(ref_x[l], ops.x[l], ops.w[l], acc_x) : ref_x[l];
				nh[l] = mac_en ? accumulate(ref_h[l], ops.h[l], ops.u[l], acc_h) : ref_h[l];
			end
			ref_x     <= nx;
			ref_h     <= nh;
			eval_pipe <= {eval_pipe[1:0], eval_in};
			// last term, so the whole cell result is known now
			if (eval_in) begin
				g.valid      = 1'b1;
				g.a          = tanh_clip(gate_sum(nx[GATE_A], nh[GATE_A], bias.b_a));
				g.i          = sigmoid_clip(gate_sum(nx[GATE_I], nh[GATE_I], bias.b_i));
				g.f          = sigmoid_clip(gate_sum(nx[GATE_F], nh[GATE_F], bias.b_f));
				g.o          = sigmoid_clip(gate_sum(nx[GATE_O], nh[GATE_O], bias.b_o));
				g.prev_state = prev_state;
				r.c = saturate(scaled_product(g.a, g.i) + scaled_product(g.f, prev_state));
				r.h = saturate(scaled_product(tanh_clip(r.c), g.o));
				ref_bias          <= bias;
				ref_prev          <= prev_state;
				exp_gates[wr_idx] <= g;
				exp_cell[wr_idx]  <= r;
				wr_idx            <= wr_idx + 1'b1;
			end
			// read pointers step once the stage has shown its result
			if (eval_pipe[1])
				gate_idx <= gate_idx + 1'b1;
			if (eval_pipe[2])
				cell_idx <= cell_idx + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks, sampled on the falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic flag_mismatch(input string msg);
		n_fail++;
		$display("MISMATCH at time %0t: %s", $time, msg);
	endtask

	task automatic flag_failure(input string msg);
		n_fail++;
		$display("error at time %0t: %s", $time, msg);
	endtask

	a_sums_valid: assert property (@(negedge clk) disable iff (!arst_n)
		sums.valid == eval_pipe[0])
		else flag_mismatch("stage 1 valid out of step with the last term");

	a_sums: assert property (@(negedge clk) disable iff (!arst_n)
		sums.x_sum == ref_x && sums.h_sum == ref_h)
		else flag_mismatch("stage 1 sums differ from the model");

	// bias and previous state taken with the last term
	a_side: assert property (@(negedge clk) disable iff (!arst_n)
		sums.valid |-> sums.bias == ref_bias && sums.prev_state == ref_prev)
		else flag_mismatch("captured bias or previous state differs from the model");

	a_gates: assert property (@(negedge clk) disable iff (!arst_n)
		gates.valid |-> gates == exp_gates[gate_idx])
		else flag_mismatch("activated gates differ from the model");

	// three cycles from the last term to the result
	a_latency: assert property (@(negedge clk) disable iff (!arst_n)
		valid == eval_pipe[2])
		else flag_mismatch("o_valid not three cycles after i_eval");

	a_cell: assert property (@(negedge clk) disable iff (!arst_n)
		valid |-> cell_res == exp_cell[cell_idx])
		else flag_mismatch("cell state or hidden output differs from the model");

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		logic [31:0] s;
		s = rng_state;
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		rng_state = s;
		return s;
	endfunction

	// 22-bit slice sign extended, so -2..+2
	function automatic fix_t rand_operand();
		logic [31:0]                  r;
		logic signed [`LSTM_FRAC+1:0] s;
		r = next_rand();
		s = r[`LSTM_FRAC+1:0];
		return fix_t'(s);
	endfunction

	task automatic idle_inputs();
		mac_en     = 1'b0;
		acc_x      = 1'b0;
		acc_h      = 1'b0;
		eval_in    = 1'b0;
		ops        = '0;
		bias       = '0;
		prev_state = '0;
	endtask

	task automatic drive_term(input logic add_x, input logic add_h, input logic last);
		@(negedge clk);
		for (int l = 0; l < `LSTM_LANES; l++) begin
			ops.x[l] = rand_operand();
			ops.w[l] = rand_operand();
			ops.h[l] = rand_operand();
			ops.u[l] = rand_operand();
		end
		bias.b_a   = rand_operand();
		bias.b_i   = rand_operand();
		bias.b_f   = rand_operand();
		bias.b_o   = rand_operand();
		prev_state = rand_operand();
		mac_en     = 1'b1;
		acc_x      = add_x;
		acc_h      = add_h;
		eval_in    = last;
	endtask

	task automatic drive_idle();
		@(negedge clk);
		mac_en  = 1'b0;
		eval_in = 1'b0;
	endtask

	// full-scale operands, input gate pushed negative, candidate either way
	task automatic drive_extreme(input logic add, input logic last, input logic neg_a);
		fix_t big;
		fix_t neg_full;
		big      = fix_t'(`LSTM_MAX);
		neg_full = fix_t'(`LSTM_MIN);
		@(negedge clk);
		for (int l = 0; l < `LSTM_LANES; l++) begin
			ops.x[l] = big;
			ops.w[l] = big;
			ops.h[l] = big;
			ops.u[l] = big;
		end
		ops.w[GATE_I] = neg_full;
		ops.u[GATE_I] = neg_full;
		if (neg_a) begin
			ops.w[GATE_A] = neg_full;
			ops.u[GATE_A] = neg_full;
		end
		bias       = '0;
		prev_state = neg_a ? neg_full : big;
		mac_en     = 1'b1;
		acc_x      = add;
		acc_h      = add;
		eval_in    = last;
	endtask

	// idles the inputs until count results showed, span is first to last
	task automatic wait_results(input int count, output int span);
		int seen;
		int cycles;
		int first;
		seen   = 0;
		cycles = 0;
		first  = 0;
		span   = 0;
		while (seen < count && cycles < 20) begin
			@(negedge clk);
			mac_en  = 1'b0;
			eval_in = 1'b0;
			cycles++;
			if (valid) begin
				if (seen == 0)
					first = cycles;
				seen++;
				span = cycles - first + 1;
			end
		end
		if (seen < count) begin
			timed_out = 1'b1;
			$display("timeout: only %0d of %0d results after %0d cycles", seen, count, cycles);
		end
	endtask

	task automatic finish_test(input string name, input int fails_before);
		n_tests++;
		$display("test %0s: %0s", name, (n_fail == fails_before && !timed_out) ? "ok" : "failed");
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_single_term();
		int fails_start;
		int span;
		fails_start = n_fail;
		for (int k = 0; k < 4; k++) begin
			drive_term(1'b0, 1'b0, 1'b1);
			wait_results(1, span);
		end
		finish_test("single term", fails_start);
	endtask

	// idle cycles in between must leave the sums alone
	task automatic test_accumulation();
		int fails_start;
		int span;
		fails_start = n_fail;
		drive_term(1'b0, 1'b0, 1'b0);
		drive_term(1'b1, 1'b1, 1'b0);
		drive_idle();
		drive_term(1'b1, 1'b1, 1'b0);
		drive_idle();
		drive_idle();
		drive_term(1'b1, 1'b1, 1'b0);
		drive_term(1'b1, 1'b1, 1'b0);
		drive_term(1'b1, 1'b1, 1'b1);
		wait_results(1, span);
		finish_test("multi-term accumulation", fails_start);
	endtask

	task automatic test_saturation();
		int fails_start;
		int span;
		fails_start = n_fail;
		drive_extreme(1'b0, 1'b0, 1'b0);
		drive_extreme(1'b1, 1'b1, 1'b0);
		drive_extreme(1'b0, 1'b1, 1'b1);
		wait_results(2, span);
		finish_test("saturation and clamping", fails_start);
	endtask

	task automatic test_back_to_back();
		int fails_start;
		int span;
		fails_start = n_fail;
		repeat (3) drive_term(1'b0, 1'b0, 1'b1);
		wait_results(3, span);
		if (!timed_out && span != 3)
			flag_failure("back-to-back results did not come out on consecutive cycles");
		finish_test("back-to-back sequences", fails_start);
	endtask

	task automatic test_reset();
		int fails_start;
		int stale;
		fails_start = n_fail;
		stale       = 0;
		repeat (3) drive_term(1'b0, 1'b0, 1'b1);
		@(negedge clk);
		arst_n  = 1'b0;
		mac_en  = 1'b0;
		eval_in = 1'b0;
		#1;
		assert (valid === 1'b0 && sums.valid === 1'b0 && gates.valid === 1'b0
			&& sums.x_sum === '0 && sums.h_sum === '0)
			else flag_failure("reset did not clear the valid bits and sums at once");
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
		// no result may surface from the dropped sequences
		repeat (8) begin
			@(negedge clk);
			if (valid)
				stale++;
		end
		assert (stale == 0)
			else flag_failure("a stale result appeared after reset release");
		finish_test("reset with results in flight", fails_start);
	endtask

	initial begin
		rng_state = 32'hd6fd74eb;
		n_fail    = 0;
		n_tests   = 0;
		timed_out = 1'b0;
		arst_n    = 1'b0;
		idle_inputs();
		repeat (2) @(negedge clk);
		arst_n = 1'b1;

		test_single_term();
		if (!timed_out)
			test_accumulation();
		if (!timed_out)
			test_saturation();
		if (!timed_out)
			test_back_to_back();
		if (!timed_out)
			test_reset();

		$display("tests run %0d, failed checks %0d", n_tests, n_fail);
		if (n_fail == 0 && !timed_out)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+.
lstm_pkg.sv
lstm_mac_array.sv
lstm_gate_activation.sv
lstm_state_update.sv
lstm_core.sv
tb_lstm_core.sv

// ==== Makefile ====
# Verilator build and run of the LSTM core testbench

VERILATOR ?= verilator
TOP       ?= tb_lstm_core
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Simulation finished: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass if the pass message is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
